// ==== lsq_macros.svh ====
// queue depth must stay a power of two equal to 2**LSQ_ID_W; memory only decodes address bits 11:2
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// queue geometry
// 16 entries, ids wrap naturally in 4 bits
`define LSQ_DEPTH 16
`define LSQ_ID_W  4

// data and address width
`define WORD_W 32

// data memory, 1024 words = 4 KB
`define MEM_WORDS 1024
`define MEM_IDX_W 10

// completion latency in cycles, counted from the edge that samples the request
// odd word index
`define FAST_LAT 1
// even word index
`define SLOW_LAT 3

`endif

// ==== lsq_pkg.sv ====
// shared queue types; register and predicate tags are fixed at 4 bits, not tied to the macros
`include "lsq_macros.svh"

package lsq_pkg;

  // plain vectors
  typedef logic [`WORD_W-1:0]   word_t;
  typedef logic [`LSQ_ID_W-1:0] lsq_id_t;
  typedef logic [3:0]           reg_tag_t;
  typedef logic [3:0]           pred_tag_t;

  // core request, qualified by the rd or wr strobe
  typedef struct packed {
    word_t     addr;
    word_t     data;
    reg_tag_t  wb;
    pred_tag_t pred;
  } core_req_t;

  // request to the data cache, rw high for a store
  typedef struct packed {
    logic    valid;
    logic    rw;
    lsq_id_t id;
    word_t   addr;
    word_t   data;
  } mem_req_t;

  // completion from the data cache, data is 0 for stores
  typedef struct packed {
    logic    valid;
    lsq_id_t id;
    word_t   data;
  } mem_resp_t;

  // allocation record, fills the tag side of an entry
  typedef struct packed {
    logic      valid;
    lsq_id_t   id;
    logic      rw;
    reg_tag_t  wb;
    pred_tag_t pred;
  } alloc_t;

  // retired entry going back to the core
  typedef struct packed {
    logic      rw;
    word_t     data;
    reg_tag_t  wb;
    pred_tag_t pred;
  } retire_t;

endpackage

// ==== lsq_issue.sv ====
// strobes while full are dropped silently; core must watch o_full, rd and wr must not both be set
`include "lsq_macros.svh"

module lsq_issue import lsq_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      i_mem_rd,
  input  logic      i_mem_wr,
  input  core_req_t i_req,
  input  logic      i_ret_done,
  output mem_req_t  o_mem_req,
  output alloc_t    o_alloc,
  output logic      o_full,
  output logic      o_empty
);

  // occupancy needs one extra bit to hold the full count
  logic [`LSQ_ID_W:0] occ;
  lsq_id_t            tail_ptr;
  logic               accept;

  // a request is taken only when there is room
  assign accept = (i_mem_rd || i_mem_wr) && !o_full;

  // tail pointer and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      tail_ptr <= '0;
      occ      <= '0;
    end else begin
      if (accept) begin
        // wrap at the queue depth
        if (tail_ptr == lsq_id_t'(`LSQ_DEPTH - 1)) begin
          tail_ptr <= '0;
        end else begin
          tail_ptr <= tail_ptr + 1'b1;
        end
      end
      // issue and retire in the same cycle cancel out
      case ({accept, i_ret_done})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

  // valid strobes, one cycle after the core strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      o_mem_req.valid <= 1'b0;
      o_alloc.valid   <= 1'b0;
    end else begin
      o_mem_req.valid <= accept;
      o_alloc.valid   <= accept;
    end
  end

  // payload, both records carry the tail id
  always_ff @(posedge clk) begin
    o_mem_req.rw   <= i_mem_wr;
    o_mem_req.id   <= tail_ptr;
    o_mem_req.addr <= i_req.addr;
    o_mem_req.data <= i_req.data;
    o_alloc.id     <= tail_ptr;
    o_alloc.rw     <= i_mem_wr;
    o_alloc.wb     <= i_req.wb;
    o_alloc.pred   <= i_req.pred;
  end

  // levels straight from the counter
  assign o_full  = (occ == (`LSQ_ID_W+1)'(`LSQ_DEPTH));
  assign o_empty = (occ == '0);

endmodule

// ==== dcache_model.sv ====
// behavioural data cache, no stall; addresses alias above bit 11 and the low two bits are ignored
`include "lsq_macros.svh"

module dcache_model import lsq_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  mem_req_t  i_mem_req,
  output mem_resp_t o_resp_fast,
  output mem_resp_t o_resp_slow
);

  // word index, address bits 11 down to 2
  logic [`MEM_IDX_W-1:0] req_idx;

  word_t mem [`MEM_WORDS];

  // access stage, result of the request edge
  logic    acc_valid;
  logic    acc_odd;
  lsq_id_t acc_id;
  word_t   acc_data;

  // completion pipelines, last stage drives the port
  mem_resp_t fast_pipe [`FAST_LAT];
  mem_resp_t slow_pipe [`SLOW_LAT];

  assign req_idx = i_mem_req.addr[`MEM_IDX_W+1:2];

  // word i starts out holding i
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem[i] <= word_t'(i);
      end
    end else if (i_mem_req.valid && i_mem_req.rw) begin
      mem[req_idx] <= i_mem_req.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= i_mem_req.valid;
    end
  end

  // read sees the word before a write at the same edge
  // stores complete with zero data
  always_ff @(posedge clk) begin
    acc_odd  <= req_idx[0];
    acc_id   <= i_mem_req.id;
    acc_data <= i_mem_req.rw ? '0 : mem[req_idx];
  end

  // odd index goes fast, even index goes slow
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FAST_LAT; i++) begin
        fast_pipe[i].valid <= 1'b0;
      end
      for (int i = 0; i < `SLOW_LAT; i++) begin
        slow_pipe[i].valid <= 1'b0;
      end
    end else begin
      fast_pipe[0] <= '{valid: acc_valid && acc_odd, id: acc_id, data: acc_data};
      for (int i = 1; i < `FAST_LAT; i++) begin
        fast_pipe[i] <= fast_pipe[i-1];
      end
      slow_pipe[0] <= '{valid: acc_valid && !acc_odd, id: acc_id, data: acc_data};
      for (int i = 1; i < `SLOW_LAT; i++) begin
        slow_pipe[i] <= slow_pipe[i-1];
      end
    end
  end

  // at most one completion per port per cycle
  // ids differ whenever both fire together
  assign o_resp_fast = fast_pipe[`FAST_LAT-1];
  assign o_resp_slow = slow_pipe[`SLOW_LAT-1];

endmodule

// ==== lsq_retire.sv ====
// retires strictly in id order, one per cycle, no back-pressure; an id is never reallocated early
`include "lsq_macros.svh"

module lsq_retire import lsq_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  alloc_t    i_alloc,
  input  mem_resp_t i_resp_fast,
  input  mem_resp_t i_resp_slow,
  output logic      o_ret_valid,
  output retire_t   o_ret,
  output logic      o_ret_done
);

  // per-entry state
  logic [`LSQ_DEPTH-1:0] done;
  logic                  rw_q   [`LSQ_DEPTH];
  word_t                 data_q [`LSQ_DEPTH];
  reg_tag_t              wb_q   [`LSQ_DEPTH];
  pred_tag_t             pred_q [`LSQ_DEPTH];

  // oldest outstanding entry
  lsq_id_t head_ptr;
  logic    head_ready;

  assign head_ready = done[head_ptr];

  // tag side, written once per allocation
  always_ff @(posedge clk) begin
    if (i_alloc.valid) begin
      rw_q[i_alloc.id]   <= i_alloc.rw;
      wb_q[i_alloc.id]   <= i_alloc.wb;
      pred_q[i_alloc.id] <= i_alloc.pred;
    end
  end

  // data side, both ports can land in the same cycle
  // their ids never match, so two writes are safe
  always_ff @(posedge clk) begin
    if (i_resp_fast.valid) begin
      data_q[i_resp_fast.id] <= i_resp_fast.data;
    end
    if (i_resp_slow.valid) begin
      data_q[i_resp_slow.id] <= i_resp_slow.data;
    end
  end

  // done flags, head pointer and retire strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      done        <= '0;
      head_ptr    <= '0;
      o_ret_valid <= 1'b0;
    end else begin
      o_ret_valid <= head_ready;
      if (i_resp_fast.valid) begin
        done[i_resp_fast.id] <= 1'b1;
      end
      if (i_resp_slow.valid) begin
        done[i_resp_slow.id] <= 1'b1;
      end
      // the head is already complete, so no port targets it here
      if (head_ready) begin
        done[head_ptr] <= 1'b0;
        if (head_ptr == lsq_id_t'(`LSQ_DEPTH - 1)) begin
          head_ptr <= '0;
        end else begin
          head_ptr <= head_ptr + 1'b1;
        end
      end
    end
  end

  // retire payload, only meaningful while o_ret_valid is high
  always_ff @(posedge clk) begin
    if (head_ready) begin
      o_ret <= '{
        rw:   rw_q[head_ptr],
        data: data_q[head_ptr],
        wb:   wb_q[head_ptr],
        pred: pred_q[head_ptr]
      };
    end
  end

  // the issue side counts down on every retire
  assign o_ret_done = o_ret_valid;

endmodule

// ==== lsq_top.sv ====
// load/store queue with cache model; o_ret_valid is a bare pulse and the core must stop while o_full
`include "lsq_macros.svh"

module lsq_top import lsq_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  // core request side
  input  logic      i_mem_rd,
  input  logic      i_mem_wr,
  input  core_req_t i_req,
  // core retire side
  output logic      o_ret_valid,
  output retire_t   o_ret,
  output logic      o_empty,
  output logic      o_full
);

  // issue to cache model
  mem_req_t  mem_req;
  // issue to retire
  alloc_t    alloc;
  // cache model completions
  mem_resp_t resp_fast;
  mem_resp_t resp_slow;
  // retire back to issue, frees one slot
  logic      ret_done;

  // accepts requests, hands out ids
  lsq_issue u_issue (
    .clk        (clk),
    .rst        (rst),
    .i_mem_rd   (i_mem_rd),
    .i_mem_wr   (i_mem_wr),
    .i_req      (i_req),
    .i_ret_done (ret_done),
    .o_mem_req  (mem_req),
    .o_alloc    (alloc),
    .o_full     (o_full),
    .o_empty    (o_empty)
  );

  // variable-latency memory
  dcache_model u_dcache (
    .clk         (clk),
    .rst         (rst),
    .i_mem_req   (mem_req),
    .o_resp_fast (resp_fast),
    .o_resp_slow (resp_slow)
  );

  // collects completions, retires in order
  lsq_retire u_retire (
    .clk         (clk),
    .rst         (rst),
    .i_alloc     (alloc),
    .i_resp_fast (resp_fast),
    .i_resp_slow (resp_slow),
    .o_ret_valid (o_ret_valid),
    .o_ret       (o_ret),
    .o_ret_done  (ret_done)
  );

endmodule

// ==== lsq_properties.sv ====
// protocol and completion id checks on lsq_top; every check is held off while rst is high
module lsq_properties import lsq_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      i_mem_rd,
  input logic      i_mem_wr,
  input logic      o_full,
  input logic      o_empty,
  input logic      o_ret_valid,
  input mem_resp_t resp_fast,
  input mem_resp_t resp_slow
);
  timeunit 1ns;
  timeprecision 1ps;

  // core must hold off while the queue is full
  assert property (@(posedge clk) disable iff (rst) o_full |-> !(i_mem_rd || i_mem_wr))
    else $error("request strobe while the queue is full");

  // a retire needs an entry that was outstanding the cycle before
  assert property (@(posedge clk) disable iff (rst) o_ret_valid |-> !$past(o_empty))
    else $error("retire pulse while the queue was empty");

  // one kind of access per strobe
  assert property (@(posedge clk) disable iff (rst) !(i_mem_rd && i_mem_wr))
    else $error("read and write strobes high together");

  // both ports firing at once must target different entries
  assert property (@(posedge clk) disable iff (rst)
                   (resp_fast.valid && resp_slow.valid) |-> (resp_fast.id != resp_slow.id))
    else $error("fast and slow completions carry the same id");

endmodule

bind lsq_top lsq_properties u_props (
  .clk         (clk),
  .rst         (rst),
  .i_mem_rd    (i_mem_rd),
  .i_mem_wr    (i_mem_wr),
  .o_full      (o_full),
  .o_empty     (o_empty),
  .o_ret_valid (o_ret_valid),
  .resp_fast   (resp_fast),
  .resp_slow   (resp_slow)
);

// ==== tb_lsq.sv ====
// self-checking testbench; the model only knows address bits 11:2 and never issues while o_full
`include "lsq_macros.svh"

module tb_lsq import lsq_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // test lengths
  localparam int N_LOADS  = 20;
  localparam int N_STORES = 20;
  localparam int N_ALT    = 32;
  localparam int N_MIXED  = 300;
  localparam int MAX_GAP  = 3;
  // worst case has every mixed request wait its longest gap
  localparam int STIM_CYCLES = N_LOADS + 2 * N_STORES + N_ALT + N_MIXED * (MAX_GAP + 1);
  localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

  logic      clk;
  logic      rst;
  logic      i_mem_rd;
  logic      i_mem_wr;
  core_req_t i_req;
  logic      o_ret_valid;
  retire_t   o_ret;
  logic      o_empty;
  logic      o_full;

  // reference model memory image and expected retires in request order
  word_t   model_mem [`MEM_WORDS];
  retire_t exp_q [$];
  word_t   store_addr [N_STORES];

  logic [31:0] rng_state;
  int cycles   = 0;
  int n_checks = 0;
  int n_errors = 0;
  int n_reqs   = 0;
  int n_rets   = 0;

  lsq_top UUT (
    .clk         (clk),
    .rst         (rst),
    .i_mem_rd    (i_mem_rd),
    .i_mem_wr    (i_mem_wr),
    .i_req       (i_req),
    .o_ret_valid (o_ret_valid),
    .o_ret       (o_ret),
    .o_empty     (o_empty),
    .o_full      (o_full)
  );

  // 10 ns clock
  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // word aligned address inside the 4 KB the cache decodes
  function word_t rand_addr();
    return next_rand() & 32'h0000_0ffc;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, want);
    end
  endtask

  task automatic check_tag(input string name, input reg_tag_t got, input reg_tag_t want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, want);
    end
  endtask

  // drives one strobe cycle starting 1 ns after a rising edge
  task automatic issue_req(input logic wr, input word_t addr, input word_t data,
                           input reg_tag_t wb, input pred_tag_t pred);
    retire_t               want;
    logic [`MEM_IDX_W-1:0] idx;
    // hold off while the queue is full
    while (o_full) begin
      @(posedge clk);
      #1;
    end
    idx       = addr[`MEM_IDX_W+1:2];
    want.rw   = wr;
    want.wb   = wb;
    want.pred = pred;
    // stores retire with zero data
    // loads see every older store
    if (wr) begin
      want.data      = '0;
      model_mem[idx] = data;
    end else begin
      want.data = model_mem[idx];
    end
    exp_q.push_back(want);
    n_reqs++;
    i_mem_rd = !wr;
    i_mem_wr = wr;
    i_req    = '{addr: addr, data: data, wb: wb, pred: pred};
    @(posedge clk);
    #1;
    i_mem_rd = 1'b0;
    i_mem_wr = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // waits until every expected retire has been seen
  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // retire pulse is stable mid-cycle
  always @(negedge clk) begin : monitor
    retire_t want;
    if (!rst && o_ret_valid === 1'b1) begin
      n_rets++;
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("retire at %0t with no outstanding request in the model", $time);
      end else begin
        want = exp_q.pop_front();
        check_bit("o_ret.rw", o_ret.rw, want.rw);
        check_word("o_ret.data", o_ret.data, want.data);
        check_tag("o_ret.wb", o_ret.wb, want.wb);
        check_tag("o_ret.pred", o_ret.pred, want.pred);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the queue did not retire every request", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    int          err_start;
    int          req_start;
    logic [31:0] r;
    rst       = 1'b1;
    i_mem_rd  = 1'b0;
    i_mem_wr  = 1'b0;
    i_req     = '0;
    rng_state = 32'hff35;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model_mem[i] = word_t'(i);
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // test 1 loads straight after reset and expects the word index back
    err_start = n_errors;
    req_start = n_reqs;
    for (int i = 0; i < N_LOADS; i++) begin
      r = next_rand();
      issue_req(1'b0, rand_addr(), next_rand(), r[3:0], r[7:4]);
    end
    wait_drain();
    $display("test 1 loads after reset: %0d requests, %0d errors",
             n_reqs - req_start, n_errors - err_start);

    // test 2 stores and then loads back from the same words
    err_start = n_errors;
    req_start = n_reqs;
    for (int i = 0; i < N_STORES; i++) begin
      r             = next_rand();
      store_addr[i] = rand_addr();
      issue_req(1'b1, store_addr[i], next_rand(), r[3:0], r[7:4]);
    end
    for (int i = 0; i < N_STORES; i++) begin
      r = next_rand();
      issue_req(1'b0, store_addr[i], next_rand(), r[3:0], r[7:4]);
    end
    wait_drain();
    $display("test 2 store then load: %0d requests, %0d errors",
             n_reqs - req_start, n_errors - err_start);

    // test 3 puts even and odd words back to back so completions overtake
    err_start = n_errors;
    req_start = n_reqs;
    for (int i = 0; i < N_ALT; i++) begin
      r = next_rand();
      issue_req(r[10], word_t'({r[`MEM_IDX_W-1:1], i[0], 2'b00}), next_rand(),
                r[14:11], r[18:15]);
    end
    wait_drain();
    $display("test 3 out of order completion: %0d requests, %0d errors",
             n_reqs - req_start, n_errors - err_start);

    // test 4 sends mixed traffic with random gaps
    err_start = n_errors;
    req_start = n_reqs;
    for (int i = 0; i < N_MIXED; i++) begin
      r = next_rand();
      idle(int'(r[1:0]));
      issue_req(r[2], rand_addr(), next_rand(), r[6:3], r[10:7]);
    end
    wait_drain();
    $display("test 4 mixed random: %0d requests, %0d errors",
             n_reqs - req_start, n_errors - err_start);

    // test 5 looks at the idle queue once the last retire has freed its slot
    err_start = n_errors;
    idle(1);
    check_bit("o_empty", o_empty, 1'b1);
    check_bit("o_full", o_full, 1'b0);
    if (n_rets != n_reqs) begin
      n_errors++;
      $display("retire count %0d does not match request count %0d", n_rets, n_reqs);
    end
    $display("test 5 drained queue: %0d errors", n_errors - err_start);

    $display("checks %0d, errors %0d, requests %0d, retires %0d",
             n_checks, n_errors, n_reqs, n_rets);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
lsq_pkg.sv
lsq_issue.sv
dcache_model.sv
lsq_retire.sv
lsq_top.sv
lsq_properties.sv
tb_lsq.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the load/store queue testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_lsq -f list.f -o tb_lsq_sim \
  > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/tb_lsq_sim > sim.log 2>&1 || echo "simulator exited with an error status"
grep -q "=== PASS ===" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed, see sim.log"; exit 1; }
